//--- sim.f
+incdir+source
source/carry_pkg.sv
source/carry_classifier.sv
source/pending_byte_fifo.sv
source/carry_release.sv
source/carry_resolve_top.sv
test/tb_clock_gen.sv
test/tb_carry_resolve.sv

//--- Makefile
# Verilator build and run of the carry-resolution stage testbench

VERILATOR ?= verilator
TOP       ?= tb_carry_resolve
RTL_TOP   ?= carry_resolve_top
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# The run passes only if the log holds the pass line
run: build
	$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 ; cat $(LOG)
	@grep -qx '\*\* PASS \*\*' $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- test/tb_carry_resolve.sv
/*
 * Testbench for the carry-resolution stage: directed and random symbols,
 * a model of held and expected bytes, and a sink with a random ack delay
 */
`timescale 1ns/10ps

module tb_carry_resolve;
    import carry_pkg::*;

    localparam int ACK_TIMEOUT = 400;

    logic       clk;
    logic       reset;
    logic       in_req;
    in_symbol_t in_symbol;
    logic       in_ack;
    logic       out_req;
    logic       out_ack;
    byte_t      out_byte;

    // Bytes the model still holds, and bytes it owes the output
    byte_t held[$];
    byte_t expected[$];
    byte_t expected_byte;
    logic  release_ordered;
    logic  req_seen;
    logic  ack_slow;
    logic  hung;
    int    seed;
    int    data_errors;
    int    order_errors;
    int    timeout_errors;
    int    ack_delay;
    int    ack_cycles;
    int    seq;
    int    n;

    tb_clock_gen i_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    carry_resolve_top i_dut (
        .clk       (clk),
        .reset     (reset),
        .in_req    (in_req),
        .in_symbol (in_symbol),
        .in_ack    (in_ack),
        .out_req   (out_req),
        .out_ack   (out_ack),
        .out_byte  (out_byte)
    );

    // ==============================
    // Reference model
    // ==============================

    // A plain 255 joins the held run, anything else makes the held bytes final
    function automatic void model_symbol(input in_symbol_t sym);
        if (sym.flush) begin
            foreach (held[i]) begin
                expected.push_back(held[i]);
            end
            held.delete();
            release_ordered = 1'b1;
        end else if (!sym.carry && sym.data == 8'hff) begin
            held.push_back(sym.data);
        end else begin
            // Carry 1 turns the leading byte into byte plus one and each 255 into 0
            foreach (held[i]) begin
                expected.push_back(held[i] + byte_t'(sym.carry));
            end
            held.delete();
            held.push_back(sym.data);
            release_ordered = 1'b1;
        end
    endfunction

    // ==============================
    // Output monitor and sink
    // ==============================

    // Each byte is checked at the first falling edge that sees out_req high
    always @(negedge clk) begin
        if (reset) begin
            req_seen = 1'b0;
        end else begin
            if (out_req && !req_seen) begin
                a_release_ordered: assert (release_ordered) else begin
                    order_errors++;
                    $display("[ERROR] %0t: byte %h came out before any release", $time,
                             out_byte);
                end
                a_byte_owed: assert (expected.size() > 0) else begin
                    order_errors++;
                    $display("[ERROR] %0t: byte %h came out, none expected", $time, out_byte);
                end
                if (expected.size() > 0) begin
                    expected_byte = expected.pop_front();
                    a_byte_value: assert (out_byte == expected_byte) else begin
                        data_errors++;
                        $display("[ERROR] %0t: out_byte expected %h, got %h", $time,
                                 expected_byte, out_byte);
                    end
                end
            end
            req_seen = out_req;
        end
    end

    // The sink acks after 0 to 3 cycles, or always 3 in slow mode
    always begin
        @(negedge clk);
        if (!reset && out_req && !out_ack) begin
            ack_delay = ack_slow ? 3 : $unsigned($random(seed)) % 4;
            repeat (ack_delay) @(posedge clk);
            @(posedge clk);
            out_ack <= 1'b1;
            ack_cycles = 0;
            @(negedge clk);
            while (out_req && ack_cycles < ACK_TIMEOUT) begin
                @(negedge clk);
                ack_cycles++;
            end
            if (out_req) begin
                timeout_errors++;
                hung = 1'b1;
                $display("Timeout: out_req stayed high after out_ack was raised");
            end
            @(posedge clk);
            out_ack <= 1'b0;
        end
    end

    // ==============================
    // Input driver
    // ==============================

    task automatic wait_in_ack(input logic level);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (in_ack !== level && cycles < ACK_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (in_ack !== level) begin
            timeout_errors++;
            hung = 1'b1;
            $display("Timeout: in_ack did not go %s", level ? "high" : "low");
        end
    endtask

    task automatic send_symbol(input logic flush, input logic carry, input byte_t data);
        in_symbol_t sym;
        if (hung) begin
            return;
        end
        sym.flush = flush;
        sym.carry = carry;
        sym.data  = data;
        model_symbol(sym);
        // The symbol settles one edge before the request
        @(posedge clk);
        in_symbol <= sym;
        @(posedge clk);
        in_req <= 1'b1;
        wait_in_ack(1'b1);
        if (hung) begin
            return;
        end
        // Every owed byte must be out by the time the symbol is acked
        a_all_released: assert (expected.size() == 0) else begin
            order_errors++;
            $display("[ERROR] %0t: %0d bytes still owed at in_ack", $time, expected.size());
        end
        if (flush) begin
            a_flush_empties: assert (i_dut.i_fifo.count == '0) else begin
                order_errors++;
                $display("[ERROR] %0t: buffer holds %0d bytes after a flush", $time,
                         i_dut.i_fifo.count);
            end
        end
        @(posedge clk);
        in_req <= 1'b0;
        wait_in_ack(1'b0);
    endtask

    task automatic send_flush();
        send_symbol(1'b1, 1'b0, 8'h00);
    endtask

    // Plain 255s are capped so that the held list never exceeds 15 entries
    task automatic send_random_symbol();
        int    kind;
        byte_t data;
        kind = $unsigned($random(seed)) % 8;
        data = byte_t'($random(seed));
        if (kind < 4 && held.size() < 15) begin
            send_symbol(1'b0, 1'b0, 8'hff);
        end else if (kind == 7) begin
            send_symbol(1'b0, 1'b1, data);
        end else begin
            // A random 255 here would extend the run past the cap
            send_symbol(1'b0, 1'b0, (data == 8'hff) ? 8'h00 : data);
        end
    endtask

    // Out of reset both request lines must stay low with no input
    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            a_idle_quiet: assert (!out_req && !in_ack) else begin
                order_errors++;
                $display("[ERROR] %0t: out_req or in_ack high while idle", $time);
            end
        end
    endtask

    // ==============================
    // Test sequence
    // ==============================

    initial begin
        seed            = 32'h52ab;
        release_ordered = 1'b0;
        req_seen        = 1'b0;
        ack_slow        = 1'b0;
        hung            = 1'b0;
        data_errors     = 0;
        order_errors    = 0;
        timeout_errors  = 0;
        in_req          = 1'b0;
        in_symbol       = '0;
        out_ack         = 1'b0;

        n = 0;
        @(negedge clk);
        while (reset && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (reset) begin
            timeout_errors++;
            hung = 1'b1;
            $display("Timeout: reset was never released");
        end
        check_idle(5);

        // Bytes without 255 or carry come out unchanged, one symbol late
        send_symbol(1'b0, 1'b0, 8'h10);
        send_symbol(1'b0, 1'b0, 8'h20);
        send_symbol(1'b0, 1'b0, 8'h30);
        send_flush();

        // Run of 255s closed by a plain byte stays as it is
        send_symbol(1'b0, 1'b0, 8'h41);
        repeat (3) send_symbol(1'b0, 1'b0, 8'hff);
        send_symbol(1'b0, 1'b0, 8'h42);
        send_flush();

        // Same run closed by a carry becomes 52 00 00
        send_symbol(1'b0, 1'b0, 8'h51);
        repeat (2) send_symbol(1'b0, 1'b0, 8'hff);
        send_symbol(1'b0, 1'b1, 8'h60);
        send_flush();

        // Flush of a short hold with its carry bit set still gives 70 ff unchanged
        // Then a flush on an empty buffer, then a fresh hold
        send_symbol(1'b0, 1'b0, 8'h70);
        send_symbol(1'b0, 1'b0, 8'hff);
        send_symbol(1'b1, 1'b1, 8'h00);
        send_flush();
        send_symbol(1'b0, 1'b0, 8'h80);
        send_flush();

        // Slow sink, with a carry symbol that itself holds a 255
        ack_slow = 1'b1;
        send_symbol(1'b0, 1'b0, 8'h33);
        repeat (2) send_symbol(1'b0, 1'b0, 8'hff);
        send_symbol(1'b0, 1'b1, 8'hff);
        send_flush();
        ack_slow = 1'b0;

        for (seq = 0; seq < 8; seq++) begin
            for (n = 0; n < 24; n++) begin
                send_random_symbol();
            end
            send_flush();
        end

        $display("Errors: %0d data, %0d order, %0d timeout", data_errors, order_errors,
                 timeout_errors);
        if (data_errors + order_errors + timeout_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- test/tb_clock_gen.sv
/*
 * Testbench clock and reset source: 100 ns clock, reset high for 3 cycles
 */
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    // Half period of 50 ns gives the 100 ns clock
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reset is synchronous, so it is held across three rising edges
    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- source/carry_resolve_top.sv
/*
 * Top level of the carry-resolution stage: classifier, pending byte buffer
 * and release FSM connected together
 */
`timescale 1ns/10ps

module carry_resolve_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_req,
    input  carry_pkg::in_symbol_t in_symbol,
    output logic                  in_ack,
    output logic                  out_req,
    input  logic                  out_ack,
    output carry_pkg::byte_t      out_byte
);
    import carry_pkg::*;

    // Classifier to release FSM
    release_cmd_t release_cmd;
    logic         release_done;

    // Buffer traffic
    logic         push;
    byte_t        push_data;
    logic         pop;
    byte_t        head_data;
    logic         full;
    logic         empty;

    carry_classifier i_classifier (
        .clk          (clk),
        .reset        (reset),
        .in_req       (in_req),
        .in_symbol    (in_symbol),
        .in_ack       (in_ack),
        .release_cmd  (release_cmd),
        .release_done (release_done),
        .push         (push),
        .push_data    (push_data),
        .full         (full)
    );

    // The count stays inside the buffer, the testbench reads it by hierarchy
    pending_byte_fifo i_fifo (
        .clk       (clk),
        .reset     (reset),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .head_data (head_data),
        .count     (),
        .full      (full),
        .empty     (empty)
    );

    carry_release i_release (
        .clk          (clk),
        .reset        (reset),
        .release_cmd  (release_cmd),
        .release_done (release_done),
        .pop          (pop),
        .head_data    (head_data),
        .empty        (empty),
        .out_req      (out_req),
        .out_ack      (out_ack),
        .out_byte     (out_byte)
    );

endmodule

//--- source/carry_release.sv
/*
 * Output side of the carry-resolution stage: drains the held bytes, adds the
 * released carry to each one and presents it on a four-phase output handshake
 */
`timescale 1ns/10ps

module carry_release (
    input  logic                    clk,
    input  logic                    reset,
    input  carry_pkg::release_cmd_t release_cmd,
    output logic                    release_done,
    output logic                    pop,
    input  carry_pkg::byte_t        head_data,
    input  logic                    empty,
    output logic                    out_req,
    input  logic                    out_ack,
    output carry_pkg::byte_t        out_byte
);
    import carry_pkg::*;

    release_state_t state;
    logic           carry_q;
    logic           load_carry;
    logic           load_byte;
    byte_t          next_byte;

    // ==============================
    // Byte with carry
    // ==============================

    // In idle the carry comes straight from the command, later from the latch
    assign load_carry = (state == rel_idle) ? release_cmd.carry : carry_q;

    // With carry 1 the leading byte gains one and every 255 wraps to 0
    assign next_byte = head_data + byte_t'(load_carry);

    // A new byte is loaded whenever out_req is about to rise
    assign load_byte = !empty &&
                       (((state == rel_idle) && release_cmd.start) || (state == rel_present));

    always_ff @(posedge clk) begin
        if (load_byte) begin
            out_byte <= next_byte;
        end
    end

    // The entry leaves the buffer at the edge where out_ack is first seen
    assign pop          = (state == rel_wait_ack_high) && out_ack;
    assign release_done = (state == rel_done);

    // ==============================
    // Release FSM
    // ==============================

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= rel_idle;
            out_req <= 1'b0;
            carry_q <= 1'b0;
        end else begin
            case (state)
                rel_idle: begin
                    if (release_cmd.start) begin
                        carry_q <= release_cmd.carry;
                        if (empty) begin
                            state <= rel_done;
                        end else begin
                            out_req <= 1'b1;
                            state   <= rel_wait_ack_high;
                        end
                    end
                end
                rel_wait_ack_high: begin
                    if (out_ack) begin
                        out_req <= 1'b0;
                        state   <= rel_wait_ack_low;
                    end
                end
                rel_wait_ack_low: begin
                    // Next byte only after the sink has dropped its ack
                    if (!out_ack) begin
                        state <= rel_present;
                    end
                end
                rel_present: begin
                    if (empty) begin
                        state <= rel_done;
                    end else begin
                        out_req <= 1'b1;
                        state   <= rel_wait_ack_high;
                    end
                end
                rel_done: begin
                    // Hold done until the classifier drops start
                    if (!release_cmd.start) begin
                        state <= rel_idle;
                    end
                end
                default: begin
                    state <= rel_idle;
                end
            endcase
        end
    end

    // The sink may sample out_byte at any point while out_req is high
    a_out_byte_stable: assert property (
        @(posedge clk) disable iff (reset) (out_req && $past(out_req)) |-> $stable(out_byte)
    ) else $error("out_byte changed while out_req was high");

endmodule

//--- source/pending_byte_fifo.sv
/*
 * Pending byte buffer: holds the leading candidate byte and the run of 255s
 * that follows it, in write order, with occupancy count, full and empty
 */
`timescale 1ns/10ps
`include "carry_settings.svh"

module pending_byte_fifo (
    input  logic              clk,
    input  logic              reset,
    input  logic              push,
    input  carry_pkg::byte_t  push_data,
    input  logic              pop,
    output carry_pkg::byte_t  head_data,
    output carry_pkg::count_t count,
    output logic              full,
    output logic              empty
);
    import carry_pkg::*;

    byte_t mem [`CARRY_DEPTH];
    addr_t wr_ptr;
    addr_t rd_ptr;

    // ==============================
    // Storage
    // ==============================

    // Payload only, the pointers and the count say which entries are valid
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // The oldest entry is always on the read port
    assign head_data = mem[rd_ptr];

    // ==============================
    // Pointers and occupancy
    // ==============================

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + addr_t'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + addr_t'(1);
            end
            // A push and a pop in the same cycle leave the count alone
            case ({push, pop})
                2'b10:   count <= count + count_t'(1);
                2'b01:   count <= count - count_t'(1);
                default: count <= count;
            endcase
        end
    end

    assign full  = (count == count_t'(`CARRY_DEPTH));
    assign empty = (count == '0);

    // ==============================
    // Checks
    // ==============================

    // The release FSM must see empty before it asks for another byte
    a_no_pop_when_empty: assert property (
        @(posedge clk) disable iff (reset) pop |-> !empty
    ) else $error("pop from an empty pending buffer");

    a_count_in_range: assert property (
        @(posedge clk) disable iff (reset) count <= count_t'(`CARRY_DEPTH)
    ) else $error("pending buffer count is above its depth");

endmodule

//--- source/carry_classifier.sv
/*
 * Input side of the carry-resolution stage: accepts one symbol per four-phase
 * handshake, orders a release of the held bytes when needed, then pushes
 */
`timescale 1ns/10ps

module carry_classifier (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    in_req,
    input  carry_pkg::in_symbol_t   in_symbol,
    output logic                    in_ack,
    output carry_pkg::release_cmd_t release_cmd,
    input  logic                    release_done,
    output logic                    push,
    output carry_pkg::byte_t        push_data,
    input  logic                    full
);
    import carry_pkg::*;

    classify_state_t state;
    logic            needs_release;
    logic            release_carry;

    // ==============================
    // Classification
    // ==============================

    // A plain 255 without carry can still be changed by a later carry, so it
    // only extends the held run
    // Anything else makes every held byte final
    assign needs_release = in_symbol.flush || in_symbol.carry || (in_symbol.data != '1);

    // A flush drains the buffer unchanged, whatever its carry bit says
    assign release_carry = in_symbol.carry && !in_symbol.flush;

    // in_symbol is held stable by the source until in_ack, so the data is
    // pushed straight from the input
    assign push_data = in_symbol.data;

    // The push waits here while the buffer is full
    assign push = (state == cls_push) && !full;

    assign in_ack = (state == cls_ack_high);

    // ==============================
    // Symbol FSM
    // ==============================

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= cls_idle;
            release_cmd <= '0;
        end else begin
            case (state)
                cls_idle: begin
                    if (in_req) begin
                        if (needs_release) begin
                            release_cmd.start <= 1'b1;
                            release_cmd.carry <= release_carry;
                            state             <= cls_release_wait;
                        end else begin
                            state <= cls_push;
                        end
                    end
                end
                cls_release_wait: begin
                    // Four-phase exchange with the release FSM
                    // Start drops once done is seen, then done must drop too
                    if (release_cmd.start) begin
                        if (release_done) begin
                            release_cmd.start <= 1'b0;
                        end
                    end else if (!release_done) begin
                        // A flush leaves the buffer empty for the next symbol
                        state <= in_symbol.flush ? cls_ack_high : cls_push;
                    end
                end
                cls_push: begin
                    if (!full) begin
                        state <= cls_ack_high;
                    end
                end
                cls_ack_high: begin
                    if (!in_req) begin
                        state <= cls_ack_low;
                    end
                end
                cls_ack_low: begin
                    // One cycle with in_ack low before the next symbol is taken
                    state <= cls_idle;
                end
                default: begin
                    state <= cls_idle;
                end
            endcase
        end
    end

    // A run of 255s longer than the buffer would stall the push forever,
    // since only a later symbol could free an entry
    a_push_has_room: assert property (
        @(posedge clk) disable iff (reset) (state == cls_push) |-> !full
    ) else $error("run of 255 bytes is longer than the pending buffer");

endmodule

//--- source/carry_pkg.sv
/*
 * Shared types of the carry-resolution stage: byte, pointer and count vectors,
 * the input symbol and release command structs, and the two FSM state enums
 */
`include "carry_settings.svh"

package carry_pkg;

    // ==============================
    // Vector types
    // ==============================

    // One coded output byte
    typedef logic [`CARRY_BYTE_W-1:0] byte_t;

    // Read or write pointer into the pending buffer
    typedef logic [`CARRY_ADDR_W-1:0] addr_t;

    // Occupancy of the pending buffer, one bit wider so that full fits
    typedef logic [`CARRY_ADDR_W:0] count_t;

    // ==============================
    // Structs
    // ==============================

    // One input symbol from the range coder
    // A flush releases every held byte and carries no data of its own
    typedef struct packed {
        logic  flush;
        logic  carry;
        byte_t data;
    } in_symbol_t;

    // Release order from the classifier to the release FSM
    // Carry is only meaningful while start is high
    typedef struct packed {
        logic start;
        logic carry;
    } release_cmd_t;

    // ==============================
    // FSM states
    // ==============================

    typedef enum logic [2:0] {
        cls_idle,
        cls_release_wait,
        cls_push,
        cls_ack_high,
        cls_ack_low
    } classify_state_t;

    typedef enum logic [2:0] {
        rel_idle,
        rel_present,
        rel_wait_ack_high,
        rel_wait_ack_low,
        rel_done
    } release_state_t;

endpackage

//--- source/carry_settings.svh
/*
 * Width and depth macros for the carry-resolution stage
 */
`ifndef CARRY_SETTINGS_SVH
`define CARRY_SETTINGS_SVH

// ==============================
// Byte and buffer sizes
// ==============================

// Width of one coded output byte
`define CARRY_BYTE_W 8

// Width of a pending buffer address
`define CARRY_ADDR_W 4

// Number of pending buffer entries, one leading byte plus up to fifteen 255s
// Must equal 2 to the power of CARRY_ADDR_W so that the pointers wrap cleanly
`define CARRY_DEPTH 16

`endif
